//--- logic/aluPkg.sv
// ALU data widths and types

package aluPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // One command data byte
  localparam int ByteWidth = 8;

  // Registers A, B and the adder result
  localparam int WordWidth = 16;

  //////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ByteWidth-1:0] byte_t;

  // Low lane is bits 7:0, high lane is bits 15:8
  typedef logic [WordWidth-1:0] word_t;

endpackage

//--- logic/cmdPkg.sv
// ALU command types

package cmdPkg;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////

  // Code 3 was the multiply, now ignored
  typedef enum logic [1:0] {
    opLoad     = 2'd0,
    opAdd      = 2'd1,
    opSub      = 2'd2,
    opReserved = 2'd3
  } aluOp_t;

  //////////////////////////////////////////////////////////////////////
  // Byte lane select
  //////////////////////////////////////////////////////////////////////

  // Bit 1 picks the register, bit 0 the lane
  typedef enum logic [1:0] {
    selALo = 2'd0,
    selAHi = 2'd1,
    selBLo = 2'd2,
    selBHi = 2'd3
  } regSel_t;

endpackage

//--- logic/cmdDecode.sv
// Command stage and decode
`timescale 1ns/10ps

module cmdDecode
  import aluPkg::*, cmdPkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    cmdStrobe,
  input  aluOp_t  opCode,
  input  regSel_t regSel,
  input  logic    writeMode,
  input  logic    signedMode,
  input  byte_t   dataIn,
  output logic    loadEn,
  output logic    execEn,
  output logic    subtract,
  output logic    useRegA,
  output logic    signedOp,
  output regSel_t loadSel,
  output regSel_t readSel,
  output byte_t   stageData
);

  logic    stageValid;
  aluOp_t  stageOp;
  logic    stageWrite;
  logic    isLoad;

  //////////////////////////////////////////////////////////////////////
  // Command stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      stageValid <= 1'b0;
      stageOp    <= opLoad;
      loadSel    <= selALo;
      stageWrite <= 1'b0;
      signedOp   <= 1'b0;
    end
    else
    begin
      stageValid <= cmdStrobe;
      if (cmdStrobe)
      begin
        stageOp    <= opCode;
        loadSel    <= regSel;
        stageWrite <= writeMode;
        signedOp   <= signedMode;
      end
    end
  end

  // Data byte, taken with each strobe
  always_ff @(posedge CLK)
  begin
    if (cmdStrobe)
      stageData <= dataIn;
  end

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign isLoad   = stageValid && (stageOp == opLoad);
  assign loadEn   = isLoad && stageWrite;
  // opReserved falls through with no enable
  assign execEn   = stageValid && ((stageOp == opAdd) || (stageOp == opSub));
  assign subtract = (stageOp == opSub);
  // Same bit as the load write flag
  assign useRegA  = stageWrite;

  // Read select, a load with the write bit clear
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      readSel <= selALo;
    else if (isLoad && !stageWrite)
      readSel <= loadSel;
  end

  // Register loads and arithmetic never share a stage
  onehotEnable: assert property (@(posedge CLK) disable iff (!RST)
    !(loadEn && execEn));

endmodule

//--- logic/accumRegs.sv
// Word registers A and B
`timescale 1ns/10ps

module accumRegs
  import aluPkg::*, cmdPkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    loadEn,
  input  logic    execEn,
  input  regSel_t loadSel,
  input  regSel_t readSel,
  input  byte_t   stageData,
  input  word_t   result,
  output word_t   regA,
  output word_t   regB,
  output byte_t   dataOut
);

  //////////////////////////////////////////////////////////////////////
  // Register A
  //////////////////////////////////////////////////////////////////////

  // Byte loads only, arithmetic never writes A
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      regA <= '0;
    else if (loadEn)
    begin
      case (loadSel)
        selALo:  regA[ByteWidth-1:0]         <= stageData;
        selAHi:  regA[WordWidth-1:ByteWidth] <= stageData;
        default: regA <= regA;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register B
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      regB <= '0;
    else if (execEn)
      regB <= result;
    else if (loadEn)
    begin
      case (loadSel)
        selBLo:  regB[ByteWidth-1:0]         <= stageData;
        selBHi:  regB[WordWidth-1:ByteWidth] <= stageData;
        default: regB <= regB;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output byte
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (readSel)
      selALo:  dataOut = regA[ByteWidth-1:0];
      selAHi:  dataOut = regA[WordWidth-1:ByteWidth];
      selBLo:  dataOut = regB[ByteWidth-1:0];
      default: dataOut = regB[WordWidth-1:ByteWidth];
    endcase
  end

  // Lane must be driven whenever a load lands here
  loadLaneKnown: assert property (@(posedge CLK) disable iff (!RST)
    loadEn |-> !$isunknown(loadSel));

endmodule

//--- logic/addSubUnit.sv
// Adder and status flags
`timescale 1ns/10ps

module addSubUnit
  import aluPkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  execEn,
  input  logic  subtract,
  input  logic  useRegA,
  input  logic  signedOp,
  input  byte_t stageData,
  input  word_t regA,
  input  word_t regB,
  output word_t result,
  output logic  overflow,
  output logic  negative
);

  word_t                operand;
  word_t                addend;
  logic [WordWidth:0]   sumFull;
  logic                 carryOut;
  logic                 signedOvf;
  logic                 nextOverflow;
  logic                 nextNegative;

  //////////////////////////////////////////////////////////////////////
  // Operand and adder
  //////////////////////////////////////////////////////////////////////

  // Byte operand, extended by the signed bit
  always_comb
  begin
    if (useRegA)
      operand = regA;
    else if (signedOp)
      operand = {{(WordWidth-ByteWidth){stageData[ByteWidth-1]}}, stageData};
    else
      operand = {{(WordWidth-ByteWidth){1'b0}}, stageData};
  end

  // Subtract as B + ~op + 1
  assign addend   = subtract ? ~operand : operand;
  assign sumFull  = {1'b0, regB} + {1'b0, addend} + {{WordWidth{1'b0}}, subtract};
  assign result   = sumFull[WordWidth-1:0];
  assign carryOut = sumFull[WordWidth];

  // Same-sign inputs, different-sign sum
  assign signedOvf = (regB[WordWidth-1] == addend[WordWidth-1]) &&
                     (result[WordWidth-1] != regB[WordWidth-1]);

  //////////////////////////////////////////////////////////////////////
  // Flags
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (signedOp)
    begin
      nextOverflow = signedOvf;
      nextNegative = result[WordWidth-1];
    end
    else
    begin
      // Unsigned, carry after add and borrow after subtract
      nextOverflow = !subtract && carryOut;
      nextNegative = subtract && !carryOut;
    end
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      overflow <= 1'b0;
      negative <= 1'b0;
    end
    else if (execEn)
    begin
      overflow <= nextOverflow;
      negative <= nextNegative;
    end
  end

  // Loads and read selects keep the last status
  flagsHeld: assert property (@(posedge CLK) disable iff (!RST)
    !execEn |=> ($stable(overflow) && $stable(negative)));

endmodule

//--- logic/aluTop.sv
// Byte-command accumulator ALU
`timescale 1ns/10ps

module aluTop
  import aluPkg::*, cmdPkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    cmdStrobe,
  input  aluOp_t  opCode,
  input  regSel_t regSel,
  input  logic    writeMode,
  input  logic    signedMode,
  input  byte_t   dataIn,
  output byte_t   dataOut,
  output logic    overflow,
  output logic    negative
);

  logic    loadEn;
  logic    execEn;
  logic    subtract;
  logic    useRegA;
  logic    signedOp;
  regSel_t loadSel;
  regSel_t readSel;
  byte_t   stageData;
  word_t   regA;
  word_t   regB;
  word_t   result;

  cmdDecode cmdDecode_inst (
    .CLK        (CLK),
    .RST        (RST),
    .cmdStrobe  (cmdStrobe),
    .opCode     (opCode),
    .regSel     (regSel),
    .writeMode  (writeMode),
    .signedMode (signedMode),
    .dataIn     (dataIn),
    .loadEn     (loadEn),
    .execEn     (execEn),
    .subtract   (subtract),
    .useRegA    (useRegA),
    .signedOp   (signedOp),
    .loadSel    (loadSel),
    .readSel    (readSel),
    .stageData  (stageData)
  );

  accumRegs accumRegs_inst (
    .CLK       (CLK),
    .RST       (RST),
    .loadEn    (loadEn),
    .execEn    (execEn),
    .loadSel   (loadSel),
    .readSel   (readSel),
    .stageData (stageData),
    .result    (result),
    .regA      (regA),
    .regB      (regB),
    .dataOut   (dataOut)
  );

  addSubUnit addSubUnit_inst (
    .CLK       (CLK),
    .RST       (RST),
    .execEn    (execEn),
    .subtract  (subtract),
    .useRegA   (useRegA),
    .signedOp  (signedOp),
    .stageData (stageData),
    .regA      (regA),
    .regB      (regB),
    .result    (result),
    .overflow  (overflow),
    .negative  (negative)
  );

endmodule

//--- verif/tbClock.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tbClock
(
  output logic CLK,
  output logic RST
);

  // 8 ns period
  localparam int HalfPeriod = 4;

  initial
  begin
    CLK = 1'b0;
    forever #HalfPeriod CLK = ~CLK;
  end

  // Low for 5 rising edges, released between edges
  initial
  begin
    RST = 1'b0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
  end

endmodule

//--- verif/aluTb.sv
// Accumulator ALU testbench
`timescale 1ns/10ps

module aluTb
  import aluPkg::*, cmdPkg::*;
();

  logic    CLK;
  logic    RST;
  logic    cmdStrobe;
  aluOp_t  opCode;
  regSel_t regSel;
  logic    writeMode;
  logic    signedMode;
  byte_t   dataIn;
  byte_t   dataOut;
  logic    overflow;
  logic    negative;

  // Reference model state
  word_t modelA = '0;
  word_t modelB = '0;
  logic  modelOvf = 1'b0;
  logic  modelNeg = 1'b0;

  int          errorCount = 0;
  int          testCount = 0;
  int          cmdCount = 0;
  logic [31:0] lfsrState = 32'hb9fc_591f;

  tbClock tbClock_inst (.CLK(CLK), .RST(RST));

  aluTop aluTop_inst (
    .CLK        (CLK),
    .RST        (RST),
    .cmdStrobe  (cmdStrobe),
    .opCode     (opCode),
    .regSel     (regSel),
    .writeMode  (writeMode),
    .signedMode (signedMode),
    .dataIn     (dataIn),
    .dataOut    (dataOut),
    .overflow   (overflow),
    .negative   (negative)
  );

  //////////////////////////////////////////////////////////////////////
  // Random bytes
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    lfsrNext = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function byte_t randomByte();
    byte_t b;
    int    i;
    for (i = 0; i < ByteWidth; i++)
    begin
      b[i]      = lfsrState[0];
      lfsrState = lfsrNext(lfsrState);
    end
    return b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic updateModel(input aluOp_t op, input regSel_t sel, input logic wr,
                             input logic sgn, input byte_t data);
    int sb;
    int so;
    int r;
    if (op == opLoad && wr)
    begin
      case (sel)
        selALo:  modelA[7:0]  = data;
        selAHi:  modelA[15:8] = data;
        selBLo:  modelB[7:0]  = data;
        default: modelB[15:8] = data;
      endcase
    end
    else if (op == opAdd || op == opSub)
    begin
      if (sgn)
      begin
        sb = int'($signed(modelB));
        so = wr ? int'($signed(modelA)) : int'($signed(data));
      end
      else
      begin
        sb = int'(modelB);
        so = wr ? int'(modelA) : int'(data);
      end
      r = (op == opSub) ? sb - so : sb + so;
      if (sgn)
        modelOvf = (r > 32767) || (r < -32768);
      else
        modelOvf = (op == opAdd) && (r > 65535);
      modelB   = word_t'(r);
      modelNeg = sgn ? modelB[15] : ((op == opSub) && (r < 0));
    end
  endtask

  function automatic byte_t modelLane(input regSel_t sel);
    case (sel)
      selALo:  return modelA[7:0];
      selAHi:  return modelA[15:8];
      selBLo:  return modelB[7:0];
      default: return modelB[15:8];
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic sendCmd(input aluOp_t op, input regSel_t sel, input logic wr,
                         input logic sgn, input byte_t data);
    @(negedge CLK);
    opCode     = op;
    regSel     = sel;
    writeMode  = wr;
    signedMode = sgn;
    dataIn     = data;
    cmdStrobe  = 1'b1;
    cmdCount++;
    updateModel(op, sel, wr, sgn, data);
  endtask

  // Drop the strobe and stop at the falling edge after the last commit
  task automatic drainCmds();
    @(negedge CLK);
    cmdStrobe = 1'b0;
    @(posedge CLK);
    @(negedge CLK);
  endtask

  task automatic loadWord(input logic toB, input word_t value);
    regSel_t loSel;
    regSel_t hiSel;
    if (toB)
    begin
      loSel = selBLo;
      hiSel = selBHi;
    end
    else
    begin
      loSel = selALo;
      hiSel = selAHi;
    end
    sendCmd(opLoad, loSel, 1'b1, 1'b0, value[7:0]);
    sendCmd(opLoad, hiSel, 1'b1, 1'b0, value[15:8]);
  endtask

  task automatic compareByte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
    begin
      errorCount++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compareFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errorCount++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Read every lane and both flags against the model
  task automatic checkState();
    regSel_t sel;
    int      i;
    for (i = 0; i < 4; i++)
    begin
      sel = regSel_t'(i);
      sendCmd(opLoad, sel, 1'b0, 1'b0, 8'h00);
      drainCmds();
      compareByte($sformatf("dataOut lane %0d", i), dataOut, modelLane(sel));
    end
    compareFlag("overflow", overflow, modelOvf);
    compareFlag("negative", negative, modelNeg);
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    $display("Test %0d %s done, %0d mismatches", testCount, name,
             errorCount - errorsBefore);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic resetTest();
    int e;
    e = errorCount;
    checkState();
    finishTest("reset", e);
  endtask

  task automatic laneTest();
    int e;
    e = errorCount;
    sendCmd(opLoad, selALo, 1'b1, 1'b0, randomByte());
    sendCmd(opLoad, selAHi, 1'b1, 1'b0, randomByte());
    sendCmd(opLoad, selBLo, 1'b1, 1'b0, randomByte());
    sendCmd(opLoad, selBHi, 1'b1, 1'b0, randomByte());
    drainCmds();
    checkState();
    // One lane rewritten, the other three kept
    sendCmd(opLoad, selAHi, 1'b1, 1'b0, randomByte());
    drainCmds();
    checkState();
    finishTest("lanes", e);
  endtask

  task automatic unsignedTest();
    int e;
    e = errorCount;
    loadWord(1'b1, 16'hff80);
    repeat (4)
    begin
      sendCmd(opAdd, selALo, 1'b0, 1'b0, randomByte());
      drainCmds();
      checkState();
    end
    loadWord(1'b1, 16'h0005);
    sendCmd(opSub, selALo, 1'b0, 1'b0, 8'h10);
    drainCmds();
    checkState();
    compareFlag("negative", negative, 1'b1);
    repeat (3)
    begin
      sendCmd(opSub, selALo, 1'b0, 1'b0, randomByte());
      drainCmds();
      checkState();
    end
    finishTest("unsigned", e);
  endtask

  task automatic signedTest();
    int e;
    e = errorCount;
    // 7ff0 + 20 crosses into the negative range
    loadWord(1'b1, 16'h7ff0);
    sendCmd(opAdd, selALo, 1'b0, 1'b1, 8'h20);
    drainCmds();
    checkState();
    compareFlag("overflow", overflow, 1'b1);
    sendCmd(opAdd, selALo, 1'b0, 1'b1, 8'h01);
    drainCmds();
    checkState();
    compareFlag("overflow", overflow, 1'b0);
    loadWord(1'b1, 16'h8005);
    sendCmd(opSub, selALo, 1'b0, 1'b1, 8'h10);
    drainCmds();
    checkState();
    compareFlag("overflow", overflow, 1'b1);
    // 0x80 extends to -128
    loadWord(1'b1, 16'h0010);
    sendCmd(opAdd, selALo, 1'b0, 1'b1, 8'h80);
    drainCmds();
    checkState();
    compareFlag("negative", negative, 1'b1);
    finishTest("signed", e);
  endtask

  task automatic regATest();
    int e;
    e = errorCount;
    loadWord(1'b0, {randomByte(), randomByte()});
    loadWord(1'b1, {randomByte(), randomByte()});
    sendCmd(opAdd, selALo, 1'b1, 1'b0, randomByte());
    drainCmds();
    checkState();
    sendCmd(opSub, selALo, 1'b1, 1'b1, randomByte());
    drainCmds();
    checkState();
    sendCmd(opSub, selALo, 1'b1, 1'b0, randomByte());
    drainCmds();
    checkState();
    finishTest("register A operand", e);
  endtask

  task automatic backToBackTest();
    int e;
    e = errorCount;
    loadWord(1'b1, 16'h7ff0);
    sendCmd(opAdd, selALo, 1'b0, 1'b1, 8'h20);
    sendCmd(opLoad, selALo, 1'b1, 1'b0, randomByte());
    sendCmd(opLoad, selAHi, 1'b1, 1'b0, randomByte());
    sendCmd(opReserved, selBLo, 1'b1, 1'b1, randomByte());
    sendCmd(opLoad, selBHi, 1'b0, 1'b0, 8'h00);
    drainCmds();
    // Flags set by the add survive loads, selects and reserved codes
    compareFlag("overflow", overflow, 1'b1);
    compareFlag("negative", negative, 1'b1);
    checkState();
    sendCmd(opAdd, selALo, 1'b1, 1'b0, 8'h00);
    sendCmd(opSub, selALo, 1'b0, 1'b0, randomByte());
    sendCmd(opLoad, selBLo, 1'b1, 1'b0, randomByte());
    sendCmd(opAdd, selALo, 1'b0, 1'b1, randomByte());
    sendCmd(opReserved, selAHi, 1'b0, 1'b0, randomByte());
    drainCmds();
    checkState();
    finishTest("back to back", e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog and main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 20 * cmdCount + 200)
    begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: the tests made no progress after %0d cycles", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    cmdStrobe  = 1'b0;
    opCode     = opLoad;
    regSel     = selALo;
    writeMode  = 1'b0;
    signedMode = 1'b0;
    dataIn     = '0;
    wait (RST === 1'b1);
    resetTest();
    laneTest();
    unsignedTest();
    signedTest();
    regATest();
    backToBackTest();
    $display("Tests %0d, commands %0d, mismatches %0d", testCount, cmdCount, errorCount);
    if (errorCount == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- compile.f
logic/aluPkg.sv
logic/cmdPkg.sv
logic/cmdDecode.sv
logic/accumRegs.sv
logic/addSubUnit.sv
logic/aluTop.sv
verif/tbClock.sv
verif/aluTb.sv

//--- Makefile
SIMBIN := obj_dir/aluSim

all: run

build:
	verilator --binary --timing --assert -sv -f compile.f --top-module aluTb -Mdir obj_dir -o aluSim

run: build
	./$(SIMBIN) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall -sv logic/aluPkg.sv logic/cmdPkg.sv logic/cmdDecode.sv \
		logic/accumRegs.sv logic/addSubUnit.sv logic/aluTop.sv --top-module aluTop

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
